/* display_consts.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// display constants for the small DVI test mode and the TMDS symbol length
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DISPLAY_CONSTS_SVH
`define DISPLAY_CONSTS_SVH

// horizontal timing in pixels
`define H_ACTIVE 16
`define H_FP     2
`define H_SYNC   4
`define H_BP     2
// vertical timing in lines
`define V_ACTIVE 6
`define V_FP     1
`define V_SYNC   2
`define V_BP     1

`define SYNC_POL 1'b1  // sync pulses are asserted high
`define SYM_BITS 10    // bits per TMDS symbol, also clk cycles per pixel

`endif

/* display_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// display types for the pixel side, coordinates and colour channels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package display_pkg;

    // screen position, signed so blanking regions could sit below zero
    typedef logic signed [15:0] coord_t;

    // system colour, one channel of RGB555
    typedef logic [4:0] colour5_t;

    // link colour as the TMDS encoder sees it
    typedef logic [7:0] colour8_t;

endpackage

/* tmds_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TMDS link types and the DVI control period symbols
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package tmds_pkg;

    typedef logic [9:0] tmds_sym_t;           // one encoded symbol, sent LSB first
    typedef logic [1:0] tmds_ctrl_t;          // {c1, c0}, lane 0 carries {vsync, hsync}
    typedef logic signed [4:0] disparity_t;   // ones minus zeros, running count

    // control symbols, high transition count so the sink can find symbol edges
    localparam tmds_sym_t CTRL_SYM_00 = 10'b1101010100;
    localparam tmds_sym_t CTRL_SYM_01 = 10'b0010101011;
    localparam tmds_sym_t CTRL_SYM_10 = 10'b0101010100;
    localparam tmds_sym_t CTRL_SYM_11 = 10'b1010101011;

endpackage

/* tmds_chan_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one colour channel from the pixel source to its TMDS encoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

interface tmds_chan_if;
    import display_pkg::*;
    import tmds_pkg::*;

    logic       stb;   // single cycle, no back-pressure
    logic       de;    // data enable, low selects a control symbol
    colour8_t   data;  // colour, valid with stb
    tmds_ctrl_t ctrl;  // control pair, used when de is low

    modport src (
        output stb, de, data, ctrl
    );

    modport enc (
        input stb, de, data, ctrl
    );

endinterface

/* pixel_source.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pixel source, display timing and an arithmetic test pattern
// widens RGB555 to 8 bits per channel and fans out to three encoders
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "display_consts.svh"

module pixel_source (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     pix_stb,    // one per pixel, paced by the serializer
    tmds_chan_if.src chan [3]    // lane 0 blue, 1 green, 2 red
);
    import display_pkg::*;
    import tmds_pkg::*;

    localparam int H_TOTAL  = `H_ACTIVE + `H_FP + `H_SYNC + `H_BP;
    localparam int V_TOTAL  = `V_ACTIVE + `V_FP + `V_SYNC + `V_BP;
    localparam int HS_START = `H_ACTIVE + `H_FP;
    localparam int HS_END   = HS_START + `H_SYNC;
    localparam int VS_START = `V_ACTIVE + `V_FP;
    localparam int VS_END   = VS_START + `V_SYNC;

    coord_t     x;            // current pixel in line
    coord_t     y;            // current line in frame
    logic       line_end;
    logic       frame_end;
    logic       hsync;
    logic       vsync;
    logic       de;
    colour5_t   red;
    colour5_t   green;
    colour5_t   blue;
    colour8_t   lane_data [3];
    tmds_ctrl_t ctrl_q;       // {vsync, hsync} for lane 0
    logic       de_q;
    logic       stb_q;

    // 5 to 8 bits, top bits repeated below so full scale stays full scale
    function automatic colour8_t expand(input colour5_t c);
        return {c, c[4:2]};
    endfunction

    assign line_end  = (x == coord_t'(H_TOTAL - 1));
    assign frame_end = (y == coord_t'(V_TOTAL - 1));

    // timing decode from the counters
    assign hsync = (x >= HS_START && x < HS_END) ? `SYNC_POL : ~`SYNC_POL;
    assign vsync = (y >= VS_START && y < VS_END) ? `SYNC_POL : ~`SYNC_POL;
    assign de    = (x < `H_ACTIVE) && (y < `V_ACTIVE);

    // test pattern
    assign red   = colour5_t'(x);
    assign green = colour5_t'(y);
    assign blue  = colour5_t'(x + y);  // wraps mod 32

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x <= '0;
            y <= '0;
        end else if (pix_stb) begin
            if (line_end) begin
                x <= '0;
                y <= frame_end ? '0 : y + coord_t'(1);
            end else begin
                x <= x + coord_t'(1);
            end
        end
    end

    // strobe lags pix_stb by one clk, so the channel is valid in phase 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stb_q  <= 1'b0;
            de_q   <= 1'b0;
            ctrl_q <= '0;
        end else begin
            stb_q <= pix_stb;
            if (pix_stb) begin
                de_q   <= de;
                ctrl_q <= {vsync, hsync};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pix_stb) begin
            lane_data[0] <= expand(blue);
            lane_data[1] <= expand(green);
            lane_data[2] <= expand(red);
        end
    end

    // fan out, only lane 0 carries sync in the control period
    for (genvar i = 0; i < 3; i++) begin : g_lane
        assign chan[i].stb  = stb_q;
        assign chan[i].de   = de_q;
        assign chan[i].data = lane_data[i];
        assign chan[i].ctrl = (i == 0) ? ctrl_q : tmds_ctrl_t'(0);
    end

endmodule

/* tmds_encoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DVI 8b/10b TMDS encoder with running disparity and control symbols
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tmds_encoder (
    input  logic                clk,
    input  logic                rst_n,
    tmds_chan_if.enc            chan,
    output tmds_pkg::tmds_sym_t sym,      // held until the next stb
    output logic                sym_stb   // one clk after chan.stb
);
    import display_pkg::*;
    import tmds_pkg::*;

    colour8_t   d;
    logic [3:0] n1d;          // ones in the input byte
    logic [3:0] n1q;          // ones in q_m[7:0]
    logic       use_xnor;
    logic [8:0] q_m;          // transition minimised word
    disparity_t bal;          // ones minus zeros of q_m[7:0]
    disparity_t disp;         // running disparity
    disparity_t disp_next;
    tmds_sym_t  data_sym;
    tmds_sym_t  ctrl_sym;

    assign d = chan.data;

    // transition minimisation, XNOR when the byte is ones heavy
    always_comb begin
        n1d = '0;
        for (int i = 0; i < 8; i++) begin
            n1d = n1d + 4'(d[i]);
        end
        use_xnor = (n1d > 4'd4) || (n1d == 4'd4 && !d[0]);
        q_m[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ d[i]) : (q_m[i-1] ^ d[i]);
        end
        q_m[8] = ~use_xnor;  // tells the sink which chain was used
        n1q = '0;
        for (int i = 0; i < 8; i++) begin
            n1q = n1q + 4'(q_m[i]);
        end
        bal = disparity_t'({n1q, 1'b0}) - disparity_t'(8);
    end

    // DC balance, invert the word when it would push disparity further out
    always_comb begin
        data_sym[8] = q_m[8];
        if (disp == 0 || bal == 0) begin
            data_sym[9]   = ~q_m[8];
            data_sym[7:0] = q_m[8] ? q_m[7:0] : ~q_m[7:0];
            disp_next     = q_m[8] ? disp + bal : disp - bal;
        end else if ((disp > 0 && bal > 0) || (disp < 0 && bal < 0)) begin
            data_sym[9]   = 1'b1;  // inverted
            data_sym[7:0] = ~q_m[7:0];
            disp_next     = disp - bal + (q_m[8] ? disparity_t'(2) : disparity_t'(0));
        end else begin
            data_sym[9]   = 1'b0;
            data_sym[7:0] = q_m[7:0];
            disp_next     = disp + bal - (q_m[8] ? disparity_t'(0) : disparity_t'(2));
        end
    end

    always_comb begin
        unique case (chan.ctrl)
            2'b00:   ctrl_sym = CTRL_SYM_00;
            2'b01:   ctrl_sym = CTRL_SYM_01;
            2'b10:   ctrl_sym = CTRL_SYM_10;
            default: ctrl_sym = CTRL_SYM_11;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            disp    <= '0;
            sym_stb <= 1'b0;
        end else begin
            sym_stb <= chan.stb;
            if (chan.stb) begin
                disp <= chan.de ? disp_next : '0;  // control period restarts balance
            end
        end
    end

    always_ff @(posedge clk) begin
        if (chan.stb) begin
            sym <= chan.de ? data_sym : ctrl_sym;
        end
    end

endmodule

/* tmds_serializer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TMDS serializer, three data lanes plus clock lane, one bit per clk
// its phase counter sets the pixel rate for the whole pipeline
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "display_consts.svh"

module tmds_serializer (
    input  logic                clk,
    input  logic                rst_n,
    input  tmds_pkg::tmds_sym_t sym [3],
    input  logic                sym_stb [3],
    output logic                pix_stb,     // phase 9 only
    output logic [2:0]          tmds_data,   // lane 0 blue, 1 green, 2 red
    output logic                tmds_clk
);
    import tmds_pkg::*;

    localparam int PH_LAST = `SYM_BITS - 1;
    // five low then five high in phase order, bit 0 goes out first
    localparam logic [`SYM_BITS-1:0] CLK_PAT = {{(`SYM_BITS/2){1'b1}}, {(`SYM_BITS/2){1'b0}}};

    logic [3:0]           phase;
    logic [`SYM_BITS-1:0] clk_pat;    // rotates once per pixel
    tmds_sym_t            hold [3];   // last symbol seen per lane
    tmds_sym_t            shift [3];
    logic                 have_sym;   // first sym_stb captured
    logic                 running;    // first load done, clock lane enabled

    assign pix_stb  = (phase == 4'(PH_LAST));
    assign tmds_clk = running & clk_pat[0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase   <= '0;
            clk_pat <= CLK_PAT;
        end else begin
            phase   <= pix_stb ? '0 : phase + 4'd1;
            clk_pat <= {clk_pat[0], clk_pat[`SYM_BITS-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            have_sym <= 1'b0;
            running  <= 1'b0;
        end else begin
            if (sym_stb[0] || sym_stb[1] || sym_stb[2]) have_sym <= 1'b1;
            if (pix_stb && have_sym) running <= 1'b1;
        end
    end

    for (genvar i = 0; i < 3; i++) begin : g_lane
        always_ff @(posedge clk) begin
            if (sym_stb[i]) hold[i] <= sym[i];
        end

        // load at phase 9, then LSB first during phases 0 to 9
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                shift[i] <= '0;  // lane idles low before the first load
            end else if (pix_stb && have_sym) begin
                shift[i] <= hold[i];
            end else begin
                shift[i] <= shift[i] >> 1;
            end
        end

        assign tmds_data[i] = shift[i][0];
    end

endmodule

/* dvi_tx_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DVI transmit top, pixel source, three TMDS encoders and the serializer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module dvi_tx_top (
    input  logic       clk,         // serial bit clock
    input  logic       rst_n,
    output logic [2:0] tmds_data,   // lane 0 blue, 1 green, 2 red
    output logic       tmds_clk     // clock lane, one period per pixel
);
    import tmds_pkg::*;

    logic      pix_stb;        // pixel pacing from the serializer
    tmds_sym_t sym [3];        // encoded symbol per lane
    logic      sym_stb [3];

    tmds_chan_if chan [3] ();  // source to encoder, one per colour

    pixel_source i_src (
        .clk     (clk),
        .rst_n   (rst_n),
        .pix_stb (pix_stb),
        .chan    (chan)
    );

    // identical encoders, lane index picks the colour
    for (genvar i = 0; i < 3; i++) begin : g_enc
        tmds_encoder i_enc (
            .clk     (clk),
            .rst_n   (rst_n),
            .chan    (chan[i]),
            .sym     (sym[i]),
            .sym_stb (sym_stb[i])
        );
    end

    tmds_serializer i_ser (
        .clk       (clk),
        .rst_n     (rst_n),
        .sym       (sym),
        .sym_stb   (sym_stb),
        .pix_stb   (pix_stb),
        .tmds_data (tmds_data),
        .tmds_clk  (tmds_clk)
    );

endmodule

/* dvi_tx_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// serial checks on the clock lane, the idle lanes and the lane disparity
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "display_consts.svh"

module dvi_tx_checker (
    input logic       clk,
    input logic       rst_n,
    input logic [2:0] tmds_data,
    input logic       tmds_clk
);
    import tmds_pkg::*;

    localparam int FIRST_BIT = 2 * `SYM_BITS;  // first load lands on the second pix_stb

    int                   cyc;         // clk cycles since reset release
    int                   n_fail = 0;  // failed assertions so far
    logic [`SYM_BITS-1:0] win_clk;
    tmds_sym_t            win [3];
    logic                 aligned;     // windows hold one whole symbol
    logic [2:0]           ctrl;        // lane symbol is a control code
    disparity_t           disp [3];

    assign aligned = (win_clk == 10'b1111100000);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cyc     <= 0;
            win_clk <= '0;
        end else begin
            cyc     <= cyc + 1;
            win_clk <= {tmds_clk, win_clk[`SYM_BITS-1:1]};
        end
    end

    for (genvar i = 0; i < 3; i++) begin : g_lane
        assign ctrl[i] = win[i] inside {CTRL_SYM_00, CTRL_SYM_01, CTRL_SYM_10, CTRL_SYM_11};
        always_ff @(posedge clk) begin
            win[i] <= {tmds_data[i], win[i][`SYM_BITS-1:1]};
            if (!rst_n) begin
                disp[i] <= '0;
            end else if (aligned) begin  // ones minus zeros since the last control symbol
                disp[i] <= ctrl[i] ? '0 : disp[i] + disparity_t'(2 * $countones(win[i]) - 10);
            end
        end
        a_disp: assert property (@(posedge clk) disable iff (!rst_n)
            (disp[i] >= disparity_t'(-8)) && (disp[i] <= disparity_t'(8)))
            else begin
                n_fail++;
                $error("lane %0d running disparity %0d out of range", i, disp[i]);
            end
    end

    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (cyc < FIRST_BIT) |-> (tmds_data == 3'b000 && !tmds_clk))
        else begin
            n_fail++;
            $error("lanes active before the first symbol load");
        end
    a_clk: assert property (@(posedge clk) disable iff (!rst_n)
        (cyc >= FIRST_BIT) |-> (tmds_clk == ((cyc % `SYM_BITS) >= `SYM_BITS / 2)))
        else begin
            n_fail++;
            $error("clock lane left its five low five high pattern");
        end
    a_kind: assert property (@(posedge clk) disable iff (!rst_n)
        aligned |-> (ctrl == 3'b000 || ctrl == 3'b111))
        else begin
            n_fail++;
            $error("data symbol recovered as a control code");
        end

endmodule

bind dvi_tx_top dvi_tx_checker i_chk (
    .clk (clk), .rst_n (rst_n), .tmds_data (tmds_data), .tmds_clk (tmds_clk)
);

/* tb_dvi_tx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DVI transmitter testbench that recovers and decodes the serial symbols
// and compares them with a model of the mode timing and the test pattern
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "display_consts.svh"

module tb_dvi_tx;
    import display_pkg::*;
    import tmds_pkg::*;

    localparam int H_TOTAL = `H_ACTIVE + `H_FP + `H_SYNC + `H_BP;
    localparam int V_TOTAL = `V_ACTIVE + `V_FP + `V_SYNC + `V_BP;
    // lane 0 blanking symbol indexed by {vsync, hsync}
    localparam tmds_sym_t SYNC_SYM [4] = '{CTRL_SYM_00, CTRL_SYM_01, CTRL_SYM_10, CTRL_SYM_11};

    logic       clk = 1'b0;
    logic       rst_n = 1'b0;
    logic [2:0] tmds_data;
    logic       tmds_clk;
    tmds_sym_t  win [3] = '{default: '0};  // per lane with the oldest bit at 0
    tmds_sym_t  win_clk = '0;
    int         mx = 0;                     // model pixel, the first symbol is (0, 0)
    int         my = 0;
    int         n_syms = 0;
    int         n_data = 0;                 // data symbols in this line
    int         n_hs = 0;                   // hsync symbols in this line
    int         n_act = 0;                  // active lines in this frame
    int         n_vs = 0;                   // vsync lines in this frame
    int         value_errs = 0;
    int         frame_errs = 0;
    int         timeouts = 0;
    int         target;
    int         waited;

    dvi_tx_top i_dut (.*);

    always #20 clk = ~clk;

    function automatic colour8_t widen(input colour5_t c);
        return (colour8_t'(c) << 3) | (colour8_t'(c) >> 2);  // top bits refill the bottom
    endfunction

    function automatic logic is_ctrl(input tmds_sym_t s);
        return s inside {CTRL_SYM_00, CTRL_SYM_01, CTRL_SYM_10, CTRL_SYM_11};
    endfunction

    // undo the balance inversion and then the XOR or XNOR chain picked by bit 8
    function automatic colour8_t decode_data(input tmds_sym_t s);
        logic [7:0] q;
        colour8_t   d;
        q = s[9] ? ~s[7:0] : s[7:0];
        d[0] = q[0];
        for (int i = 1; i < 8; i++) begin
            d[i] = s[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
        end
        return d;
    endfunction

    task automatic check_symbol();
        logic act;
        logic hs;
        logic vs;
        act = (mx < `H_ACTIVE) && (my < `V_ACTIVE);
        hs  = (mx >= `H_ACTIVE + `H_FP) && (mx < `H_ACTIVE + `H_FP + `H_SYNC);
        vs  = (my >= `V_ACTIVE + `V_FP) && (my < `V_ACTIVE + `V_FP + `V_SYNC);
        if (act) begin
            assert (!is_ctrl(win[0]) && !is_ctrl(win[1]) && !is_ctrl(win[2])
                    && decode_data(win[2]) == widen(colour5_t'(mx))
                    && decode_data(win[1]) == widen(colour5_t'(my))
                    && decode_data(win[0]) == widen(colour5_t'(mx + my))) else begin
                value_errs++;
                $display("mismatch at %0t: pixel (%0d, %0d) got %h %h %h",
                         $time, mx, my, win[2], win[1], win[0]);
            end
        end else begin
            assert (win[0] == SYNC_SYM[{vs, hs}] && win[1] == CTRL_SYM_00
                    && win[2] == CTRL_SYM_00) else begin
                value_errs++;
                $display("mismatch at %0t: blanking (%0d, %0d) got %h %h %h",
                         $time, mx, my, win[2], win[1], win[0]);
            end
        end
        // line and frame structure as received on lane 0
        n_data += is_ctrl(win[0]) ? 0 : 1;
        n_hs   += (win[0] == CTRL_SYM_01 || win[0] == CTRL_SYM_11) ? 1 : 0;
        if (mx == 0) begin
            n_act += is_ctrl(win[0]) ? 0 : 1;
            n_vs  += (win[0] == CTRL_SYM_10) ? 1 : 0;
        end
        n_syms++;
        if (mx == H_TOTAL - 1) begin
            assert ((n_data == 0 || n_data == `H_ACTIVE) && n_hs == `H_SYNC) else begin
                frame_errs++;
                $display("mismatch at %0t: line %0d carried %0d data and %0d hsync symbols",
                         $time, my, n_data, n_hs);
            end
            n_data = 0;
            n_hs   = 0;
            if (my == V_TOTAL - 1) begin
                assert (n_act == `V_ACTIVE && n_vs == `V_SYNC) else begin
                    frame_errs++;
                    $display("mismatch at %0t: frame carried %0d active and %0d vsync lines",
                             $time, n_act, n_vs);
                end
                n_act = 0;
                n_vs  = 0;
            end
            mx = 0;
            my = (my == V_TOTAL - 1) ? 0 : my + 1;
        end else begin
            mx = mx + 1;
        end
    endtask

    // sample mid bit and take a symbol when the clock lane window lines up
    always @(negedge clk) begin
        win_clk = {tmds_clk, win_clk[`SYM_BITS-1:1]};
        for (int i = 0; i < 3; i++) begin
            win[i] = {tmds_data[i], win[i][`SYM_BITS-1:1]};
        end
        if (win_clk == 10'b1111100000) begin
            check_symbol();
        end
    end

    initial begin
        void'($urandom(22));
        target = (2 + int'($urandom % 2)) * H_TOTAL * V_TOTAL;  // two or three frames
        repeat (4) @(posedge clk);
        #2 rst_n = 1'b1;
        waited = 0;
        while (n_syms == 0 && waited < 5 * `SYM_BITS) begin
            @(posedge clk);
            waited++;
        end
        if (n_syms == 0) begin
            timeouts++;
            $display("no symbol alignment on the clock lane after reset");
        end else begin
            waited = 0;
            while (n_syms < target && waited < (target + 2) * `SYM_BITS) begin
                @(posedge clk);
                waited++;
            end
            if (n_syms < target) begin
                timeouts++;
                $display("symbol stream stalled after %0d of %0d symbols", n_syms, target);
            end
        end
        $display("symbols %0d, value errors %0d, framing errors %0d, serial errors %0d, %s %0d",
                 n_syms, value_errs, frame_errs, i_dut.i_chk.n_fail, "timeouts", timeouts);
        if (timeouts == 0 && value_errs == 0 && frame_errs == 0
                && i_dut.i_chk.n_fail == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+.
display_pkg.sv
tmds_pkg.sv
tmds_chan_if.sv
pixel_source.sv
tmds_encoder.sv
tmds_serializer.sv
dvi_tx_top.sv
dvi_tx_checker.sv
tb_dvi_tx.sv

/* run.sh */
#!/usr/bin/env bash
# build the DVI transmitter simulation with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_dvi_tx -f list.f -o sim_dvi_tx \
    && ./obj_dir/sim_dvi_tx | tee /dev/stderr | grep -x "Test OK" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
